/* hw/fma_pkg.sv */
// FP16 only with subnormals; infinity, NaN and overflow encodings are not modeled
`default_nettype none

package fma_pkg;

    localparam int FP_W     = 16;
    localparam int EXP_W    = 5;
    // mantissa including the hidden bit
    localparam int MAN_W    = 11;
    localparam int TEXP_W   = 6;
    localparam int EXP_BIAS = 15;
    localparam int EXP_MIN  = -14;

    localparam int PP_W        = 24;
    localparam int ADD_W       = 35;
    // c shifted further left than this swamps the product
    localparam int C_DOM_LIMIT = 13;

    // radix-8 window of three new bits plus the overlap bit
    typedef logic [3:0] booth_digit_t;
    typedef logic [FP_W-1:0] fp16_t;

    // true exponent; a zero field reads as the subnormal exponent
    function automatic logic signed [TEXP_W-1:0] true_exp(input fp16_t x);
        logic [EXP_W-1:0] field;
        field = x[FP_W-2 -: EXP_W];
        if (field == '0) begin
            return TEXP_W'(EXP_MIN);
        end
        return TEXP_W'(field) - TEXP_W'(EXP_BIAS);
    endfunction

    // mantissa with the hidden bit restored for normal numbers
    function automatic logic [MAN_W-1:0] full_man(input fp16_t x);
        return {x[FP_W-2 -: EXP_W] != '0, x[MAN_W-2:0]};
    endfunction

endpackage

`default_nettype wire

/* hw/fma_ifs.sv */
// stage links of one lane; plain nets with no handshake, values are valid every cycle
`timescale 1ns/1ns
`default_nettype none

// registered product and addend fields leaving the multiplier stage
interface fma_lane_if;
    import fma_pkg::*;

    logic                     sign_ab;
    logic signed [TEXP_W-1:0] exp_ab;
    logic                     sign_c;
    // c minus product spans -44 to 43 and needs one bit more than an exponent
    logic signed [TEXP_W:0]   exp_diff;
    logic [MAN_W-1:0]         man_c;
    logic [2*MAN_W-1:0]       csa_sum;

    modport src (
        output sign_ab, exp_ab, sign_c, exp_diff, man_c, csa_sum
    );

    modport dst (
        input  sign_ab, exp_ab, sign_c, exp_diff, man_c, csa_sum
    );

endinterface

// aligned sum and its leading zero information for the rounder
interface fma_sum_if;
    import fma_pkg::*;

    logic [ADD_W-1:0]         sum_mag;
    logic                     sum_sign;
    logic [TEXP_W-1:0]        lz_count;
    logic signed [TEXP_W-1:0] lz_offset;
    logic                     c_dominant;
    logic signed [TEXP_W-1:0] exp_ab;
    logic signed [TEXP_W:0]   exp_diff;
    logic [MAN_W-1:0]         man_c;

    modport src (
        output sum_mag, sum_sign, lz_count, lz_offset, c_dominant,
        output exp_ab, exp_diff, man_c
    );

    modport dst (
        input  sum_mag, sum_sign, lz_count, lz_offset, c_dominant,
        input  exp_ab, exp_diff, man_c
    );

endinterface

`default_nettype wire

/* hw/fp16_unpack.sv */
// combinational per-lane field split; a is unpacked once per row and enters as sign and exponent
`timescale 1ns/1ns
`default_nettype none

module fp16_unpack (
    input  logic signed [fma_pkg::TEXP_W-1:0] exp_a,
    input  logic                              sign_a,
    input  fma_pkg::fp16_t                    b,
    input  fma_pkg::fp16_t                    c,
    output logic                              sign_ab,
    output logic signed [fma_pkg::TEXP_W-1:0] exp_ab,
    output logic                              sign_c,
    output logic signed [fma_pkg::TEXP_W:0]   exp_diff,
    output logic [fma_pkg::MAN_W-1:0]         man_b,
    output logic [fma_pkg::MAN_W-1:0]         man_c
);
    import fma_pkg::*;

    logic signed [TEXP_W-1:0] exp_b;
    logic signed [TEXP_W-1:0] exp_c;

    // subnormals get EXP_MIN and a cleared hidden bit
    assign exp_b = true_exp(b);
    assign exp_c = true_exp(c);
    assign man_b = full_man(b);
    assign man_c = full_man(c);

    assign sign_ab = sign_a ^ b[FP_W-1];
    assign sign_c  = c[FP_W-1];

    // product exponent before normalization, bias handled at the end
    assign exp_ab = exp_a + exp_b;

    // widened so a large spread between c and the product does not wrap
    assign exp_diff = exp_c - exp_ab;

endmodule

`default_nettype wire

/* hw/booth_multiples.sv */
// shared by all lanes of a row; the negatives are ones' complement and need +1 downstream
`timescale 1ns/1ns
`default_nettype none

module booth_multiples #(
    parameter int MUL_W = fma_pkg::MAN_W + 3
) (
    input  fma_pkg::fp16_t                    a,
    output logic                              sign_a,
    output logic signed [fma_pkg::TEXP_W-1:0] exp_a,
    output logic [MUL_W-1:0]                  mul_p1,
    output logic [MUL_W-1:0]                  mul_p2,
    output logic [MUL_W-1:0]                  mul_p3,
    output logic [MUL_W-1:0]                  mul_p4,
    output logic [MUL_W-1:0]                  mul_n1,
    output logic [MUL_W-1:0]                  mul_n2,
    output logic [MUL_W-1:0]                  mul_n3,
    output logic [MUL_W-1:0]                  mul_n4
);
    import fma_pkg::*;

    logic [MAN_W-1:0] man_a;

    assign sign_a = a[FP_W-1];
    assign exp_a  = true_exp(a);
    assign man_a  = full_man(a);

    // top bit stays clear so the positives read as signed
    assign mul_p1 = MUL_W'(man_a);
    assign mul_p2 = MUL_W'(man_a) << 1;
    assign mul_p4 = MUL_W'(man_a) << 2;

    // the only multiple that needs a carry chain
    assign mul_p3 = mul_p1 + mul_p2;

    assign mul_n1 = ~mul_p1;
    assign mul_n2 = ~mul_p2;
    assign mul_n3 = ~mul_p3;
    assign mul_n4 = ~mul_p4;

endmodule

`default_nettype wire

/* hw/booth_lane_select.sv */
// stage 1 of a lane; registers every cycle, with no enable, and clears on rst
`timescale 1ns/1ns
`default_nettype none

module booth_lane_select #(
    parameter int MUL_W = fma_pkg::MAN_W + 3
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [MUL_W-1:0]                  mul_p1,
    input  logic [MUL_W-1:0]                  mul_p2,
    input  logic [MUL_W-1:0]                  mul_p3,
    input  logic [MUL_W-1:0]                  mul_p4,
    input  logic [MUL_W-1:0]                  mul_n1,
    input  logic [MUL_W-1:0]                  mul_n2,
    input  logic [MUL_W-1:0]                  mul_n3,
    input  logic [MUL_W-1:0]                  mul_n4,
    input  logic [fma_pkg::MAN_W-1:0]         man_b,
    input  logic                              sign_ab,
    input  logic signed [fma_pkg::TEXP_W-1:0] exp_ab,
    input  logic                              sign_c,
    input  logic signed [fma_pkg::TEXP_W:0]   exp_diff,
    input  logic [fma_pkg::MAN_W-1:0]         man_c,
    fma_lane_if.src                           lane
);
    import fma_pkg::*;

    localparam int NUM_PP = 4;

    logic [MAN_W+1:0]  man_b_ext;
    booth_digit_t      win [NUM_PP];
    logic [MUL_W-1:0]  sel [NUM_PP];
    logic [NUM_PP-1:0] neg;
    logic [PP_W-1:0]   pp [NUM_PP];
    logic [PP_W-1:0]   s1, c1, s2, c2;
    logic [PP_W-1:0]   prod;

    function automatic logic [PP_W-1:0] maj3(input logic [PP_W-1:0] x,
                                             input logic [PP_W-1:0] y,
                                             input logic [PP_W-1:0] z);
        return (x & y) | (y & z) | (x & z);
    endfunction

    // zero padding below the lsb and above the msb
    assign man_b_ext = {1'b0, man_b, 1'b0};

    always_comb begin
        for (int i = 0; i < NUM_PP; i++) begin
            win[i] = man_b_ext[3*i +: 4];
            neg[i] = win[i][3] && (win[i] != 4'b1111);
            case (win[i])
                4'b0001, 4'b0010: sel[i] = mul_p1;
                4'b0011, 4'b0100: sel[i] = mul_p2;
                4'b0101, 4'b0110: sel[i] = mul_p3;
                4'b0111:          sel[i] = mul_p4;
                4'b1000:          sel[i] = mul_n4;
                4'b1001, 4'b1010: sel[i] = mul_n3;
                4'b1011, 4'b1100: sel[i] = mul_n2;
                4'b1101, 4'b1110: sel[i] = mul_n1;
                default:          sel[i] = '0;
            endcase
            pp[i] = {{(PP_W - MUL_W){sel[i][MUL_W-1]}}, sel[i]} << (3 * i);
        end
        // +1 of a negative digit rides in the empty low bits of the next row
        for (int i = 1; i < NUM_PP; i++) begin
            pp[i][3*i-3] = neg[i-1];
        end
    end

    // two 3:2 levels and one carry-propagate add
    assign s1 = pp[0] ^ pp[1] ^ pp[2];
    assign c1 = maj3(pp[0], pp[1], pp[2]) << 1;
    assign s2 = s1 ^ c1 ^ pp[3];
    assign c2 = maj3(s1, c1, pp[3]) << 1;
    assign prod = s2 + c2;

    always_ff @(posedge clk) begin
        if (rst) begin
            lane.sign_ab  <= 1'b0;
            lane.exp_ab   <= '0;
            lane.sign_c   <= 1'b0;
            lane.exp_diff <= '0;
            lane.man_c    <= '0;
            lane.csa_sum  <= '0;
        end else begin
            lane.sign_ab  <= sign_ab;
            lane.exp_ab   <= exp_ab;
            lane.sign_c   <= sign_c;
            lane.exp_diff <= exp_diff;
            lane.man_c    <= man_c;
            lane.csa_sum  <= prod[2*MAN_W-1:0];
        end
    end

    // two 11-bit mantissas give at most 22 bits, so a wrong digit or an
    // unabsorbed +1 from the top window shows up above bit 21
    product_fits: assert property (
        @(posedge clk) disable iff (rst) prod[PP_W-1:2*MAN_W] == '0
    );

endmodule

`default_nettype wire

/* hw/fma_align_add.sv */
// combinational; a right-shifted c drops bits below the product lsb without feeding sticky
`timescale 1ns/1ns
`default_nettype none

module fma_align_add (
    fma_lane_if.dst lane,
    fma_sum_if.src  sum
);
    import fma_pkg::*;

    // c's lsb sits here so an equal exponent lines up with the product
    localparam int C_POS   = MAN_W - 1;
    // exponent of adder msb relative to exp_ab
    localparam int TOP_OFS = ADD_W - 1 - 2 * C_POS;

    logic                  eff_sub;
    logic                  c_dom;
    logic [TEXP_W:0]       shift_mag;
    logic [ADD_W-1:0]      c_ext;
    logic [ADD_W-1:0]      c_shift;
    logic [ADD_W-1:0]      c_addend;
    logic [ADD_W-1:0]      raw;
    logic                  raw_neg;
    logic [ADD_W-1:0]      mag;
    logic [TEXP_W-1:0]     lz;

    assign eff_sub = lane.sign_c ^ lane.sign_ab;
    assign c_dom   = lane.exp_diff > C_DOM_LIMIT;

    // positive difference moves c left, negative moves it right
    assign shift_mag = lane.exp_diff[TEXP_W] ? -lane.exp_diff : lane.exp_diff;
    assign c_ext     = ADD_W'(lane.man_c) << C_POS;
    assign c_shift   = lane.exp_diff[TEXP_W] ? (c_ext >> shift_mag) : (c_ext << shift_mag);

    // subtract as ones' complement plus carry-in
    assign c_addend = eff_sub ? ~c_shift : c_shift;
    assign raw      = c_addend + ADD_W'(lane.csa_sum) + ADD_W'(eff_sub);

    // magnitudes stay below 2^34, so bit 34 is the sign
    assign raw_neg = raw[ADD_W-1];
    assign mag     = raw_neg ? -raw : raw;

    // highest set bit wins; an all-zero sum counts as ADD_W
    always_comb begin
        lz = TEXP_W'(ADD_W);
        for (int i = 0; i < ADD_W; i++) begin
            if (mag[i]) begin
                lz = TEXP_W'(ADD_W - 1 - i);
            end
        end
    end

    assign sum.sum_mag    = mag;
    assign sum.sum_sign   = c_dom ? lane.sign_c : (lane.sign_ab ^ raw_neg);
    assign sum.lz_count   = lz;
    assign sum.lz_offset  = TEXP_W'(TOP_OFS) - lz;
    assign sum.c_dominant = c_dom;

    // the rounder rebuilds c from these when c dominates
    assign sum.exp_ab   = lane.exp_ab;
    assign sum.exp_diff = lane.exp_diff;
    assign sum.man_c    = lane.man_c;

endmodule

`default_nettype wire

/* hw/fma_normalize_round.sv */
// stage 2 of a lane; round to nearest even only, and exponent overflow is not saturated
`timescale 1ns/1ns
`default_nettype none

module fma_normalize_round (
    input  logic           clk,
    input  logic           rst,
    fma_sum_if.dst         sum,
    output fma_pkg::fp16_t product
);
    import fma_pkg::*;

    localparam int EXT_W  = TEXP_W + 2;
    localparam int FRAC_W = MAN_W - 1;

    logic signed [EXT_W-1:0] exp_norm;
    logic signed [EXT_W-1:0] exp_res;
    logic signed [EXT_W-1:0] exp_fin;
    logic signed [EXT_W-1:0] exp_c;
    logic                    clamp;
    logic [EXT_W-1:0]        clamp_shift;
    logic [TEXP_W-1:0]       shamt;
    logic [ADD_W-1:0]        shifted;
    logic [MAN_W-1:0]        man_pre;
    logic [MAN_W-1:0]        man_rnd;
    logic                    guard, rnd, sticky;
    logic                    round_up, carry, hidden;
    logic [EXP_W-1:0]        field_sum;
    logic [EXP_W-1:0]        field_c;
    fp16_t                   result;

    assign exp_norm = sum.exp_ab + sum.lz_offset;

    // below EXP_MIN the shift stops at EXP_MIN and gives a subnormal
    assign clamp       = exp_norm < EXP_MIN;
    assign clamp_shift = exp_norm + EXT_W'(sum.lz_count) - EXT_W'(EXP_MIN);
    assign shamt       = clamp ? clamp_shift[TEXP_W-1:0] : sum.lz_count;
    assign exp_res     = clamp ? EXT_W'(EXP_MIN) : exp_norm;

    assign shifted = sum.sum_mag << shamt;
    assign man_pre = shifted[ADD_W-1 -: MAN_W];
    assign guard   = shifted[ADD_W-1-MAN_W];
    assign rnd     = shifted[ADD_W-2-MAN_W];
    assign sticky  = |shifted[ADD_W-3-MAN_W:0];

    // a tie goes up only when the kept lsb is odd
    assign round_up = guard & (rnd | sticky | man_pre[0]);
    assign {carry, man_rnd} = {1'b0, man_pre} + (MAN_W + 1)'(round_up);

    // carry out leaves 1.0, so the fraction field is already zero
    assign hidden    = carry | man_rnd[MAN_W-1];
    assign exp_fin   = exp_res + EXT_W'(carry);
    assign field_sum = hidden ? EXP_W'(exp_fin + EXT_W'(EXP_BIAS)) : '0;

    // a dominant c is re-encoded unchanged
    assign exp_c   = sum.exp_ab + sum.exp_diff;
    assign field_c = sum.man_c[MAN_W-1] ? EXP_W'(exp_c + EXT_W'(EXP_BIAS)) : '0;

    assign result = sum.c_dominant ? {sum.sum_sign, field_c, sum.man_c[FRAC_W-1:0]}
                                   : {sum.sum_sign, field_sum, man_rnd[FRAC_W-1:0]};

    always_ff @(posedge clk) begin
        if (rst) begin
            product <= '0;
        end else begin
            product <= result;
        end
    end

    // inputs are expected to keep a*b+c in range, so no inf encoding appears
    no_exp_overflow: assert property (
        @(posedge clk) disable iff (rst) product[FP_W-2 -: EXP_W] != '1
    );

endmodule

`default_nettype wire

/* hw/fma_row.sv */
// two-cycle latency, one row per cycle, no handshake; lane i uses bits [16*i +: 16]
`timescale 1ns/1ns
`default_nettype none

module fma_row #(
    parameter int LANES = 4
) (
    input  logic                             clk,
    input  logic                             rst,
    input  fma_pkg::fp16_t                   a,
    input  logic [LANES*fma_pkg::FP_W-1:0]   row_b,
    input  logic [LANES*fma_pkg::FP_W-1:0]   row_c,
    output logic [LANES*fma_pkg::FP_W-1:0]   row_product
);
    import fma_pkg::*;

    // widest multiple is 4*man_a plus a sign bit
    localparam int MUL_W = MAN_W + 3;

    logic                     sign_a;
    logic signed [TEXP_W-1:0] exp_a;
    logic [MUL_W-1:0]         mul_p1, mul_p2, mul_p3, mul_p4;
    logic [MUL_W-1:0]         mul_n1, mul_n2, mul_n3, mul_n4;

    // a's multiples are shared by every lane
    booth_multiples #(
        .MUL_W(MUL_W)
    ) i_multiples (
        .a      (a),
        .sign_a (sign_a),
        .exp_a  (exp_a),
        .mul_p1 (mul_p1),
        .mul_p2 (mul_p2),
        .mul_p3 (mul_p3),
        .mul_p4 (mul_p4),
        .mul_n1 (mul_n1),
        .mul_n2 (mul_n2),
        .mul_n3 (mul_n3),
        .mul_n4 (mul_n4)
    );

    for (genvar l = 0; l < LANES; l++) begin : g_lane
        logic                     sign_ab, sign_c;
        logic signed [TEXP_W-1:0] exp_ab;
        logic signed [TEXP_W:0]   exp_diff;
        logic [MAN_W-1:0]         man_b, man_c;

        fma_lane_if lane_if ();
        fma_sum_if  sum_if ();

        fp16_unpack i_unpack (
            .exp_a    (exp_a),
            .sign_a   (sign_a),
            .b        (row_b[l*FP_W +: FP_W]),
            .c        (row_c[l*FP_W +: FP_W]),
            .sign_ab  (sign_ab),
            .exp_ab   (exp_ab),
            .sign_c   (sign_c),
            .exp_diff (exp_diff),
            .man_b    (man_b),
            .man_c    (man_c)
        );

        booth_lane_select #(
            .MUL_W(MUL_W)
        ) i_select (
            .clk      (clk),
            .rst      (rst),
            .mul_p1   (mul_p1),
            .mul_p2   (mul_p2),
            .mul_p3   (mul_p3),
            .mul_p4   (mul_p4),
            .mul_n1   (mul_n1),
            .mul_n2   (mul_n2),
            .mul_n3   (mul_n3),
            .mul_n4   (mul_n4),
            .man_b    (man_b),
            .sign_ab  (sign_ab),
            .exp_ab   (exp_ab),
            .sign_c   (sign_c),
            .exp_diff (exp_diff),
            .man_c    (man_c),
            .lane     (lane_if.src)
        );

        fma_align_add i_align (
            .lane (lane_if.dst),
            .sum  (sum_if.src)
        );

        fma_normalize_round i_round (
            .clk     (clk),
            .rst     (rst),
            .sum     (sum_if.dst),
            .product (row_product[l*FP_W +: FP_W])
        );
    end

endmodule

`default_nettype wire

/* tests/tb_fma_row.sv */
// directed tests of a 4-lane row; operands stay in range as inf, NaN and overflow are not modeled
`timescale 1ns/1ns
`default_nettype none

module tb_fma_row;

    localparam int LANES       = 4;
    localparam int ROW_W       = LANES * 16;
    localparam int WATCHDOG_NS = 100000;
    // weight of the smallest subnormal is 2^-24
    localparam real ULP_MIN    = 1.0 / 16777216.0;

    logic             clk;
    logic             rst;
    logic [15:0]      a;
    logic [ROW_W-1:0] row_b;
    logic [ROW_W-1:0] row_c;
    logic [ROW_W-1:0] row_product;

    integer seed;
    int     errors;
    int     checks;

    fma_row #(
        .LANES(LANES)
    ) i_fma_row (
        .clk         (clk),
        .rst         (rst),
        .a           (a),
        .row_b       (row_b),
        .row_c       (row_c),
        .row_product (row_product)
    );

    always #5 clk = ~clk;

    // exact real to FP16 with round to nearest even and subnormal range
    function automatic logic [15:0] to_fp16(input real x);
        real         mag;
        real         man_real;
        int          e;
        int          m;
        logic        s;
        logic [4:0]  field;
        s   = x < 0.0;
        mag = s ? -x : x;
        if (mag == 0.0) begin
            return {s, 15'h0000};
        end
        e = 0;
        while (mag >= 2.0) begin
            mag = mag / 2.0;
            e++;
        end
        while (mag < 1.0 && e > -14) begin
            mag = mag * 2.0;
            e--;
        end
        man_real = mag * 1024.0;
        m        = $rtoi(man_real);
        if ((man_real - m) > 0.5 || ((man_real - m) == 0.5 && m[0])) begin
            m++;
        end
        if (m == 2048) begin
            m = 1024;
            e++;
        end
        field = (m >= 1024) ? 5'(e + 15) : 5'd0;
        return {s, field, 10'(m)};
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        int unsigned u;
        u = $random(seed);
        return lo + int'(u % 32'(hi - lo + 1));
    endfunction

    task automatic next_fall(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
        end
    endtask

    task automatic drive_row(input logic [15:0] a_w, input logic [ROW_W-1:0] b_w,
                             input logic [ROW_W-1:0] c_w);
        a     = a_w;
        row_b = b_w;
        row_c = c_w;
    endtask

    // a cleared mask bit leaves that bit of the lane unchecked
    task automatic compare_row(input logic [ROW_W-1:0] expected, input logic [ROW_W-1:0] mask,
                               input string what);
        logic [15:0] got;
        logic [15:0] want;
        for (int l = 0; l < LANES; l++) begin
            got  = row_product[l*16 +: 16] & mask[l*16 +: 16];
            want = expected[l*16 +: 16] & mask[l*16 +: 16];
            checks++;
            assert (got === want) else begin
                errors++;
                $display("Mismatch at %0t ns: row_product[%0d] (%s) got %h expected %h",
                         $time, l, what, got, want);
            end
        end
    endtask

    // inputs are taken at the next rising edge and the result is valid after the one after
    task automatic run_row(input logic [15:0] a_w, input logic [ROW_W-1:0] b_w,
                           input logic [ROW_W-1:0] c_w, input logic [ROW_W-1:0] expected,
                           input logic [ROW_W-1:0] mask, input string what);
        drive_row(a_w, b_w, c_w);
        next_fall(2);
        compare_row(expected, mask, what);
    endtask

    // |a*b| stays below 466 and |c| below 257, so the sum is exact
    task automatic build_int_row(output logic [15:0] a_w, output logic [ROW_W-1:0] b_w,
                                 output logic [ROW_W-1:0] c_w, output logic [ROW_W-1:0] e_w);
        int ai;
        int bi;
        int ci;
        ai = rand_range(1, 15);
        if (rand_range(0, 1) == 1) begin
            ai = -ai;
        end
        a_w = to_fp16(real'(ai));
        for (int l = 0; l < LANES; l++) begin
            bi = rand_range(1, 31);
            if (rand_range(0, 1) == 1) begin
                bi = -bi;
            end
            ci = rand_range(-255, 255);
            // a zero result has a sign rule of its own
            if (ai * bi + ci == 0) begin
                ci++;
            end
            b_w[l*16 +: 16] = to_fp16(real'(bi));
            c_w[l*16 +: 16] = to_fp16(real'(ci));
            e_w[l*16 +: 16] = to_fp16(real'(ai * bi + ci));
        end
    endtask

    task automatic check_identity();
        logic [ROW_W-1:0] b_w;
        for (int r = 0; r < 4; r++) begin
            for (int l = 0; l < LANES; l++) begin
                b_w[l*16 +: 16] = {1'(rand_range(0, 1)), 5'(rand_range(1, 29)),
                                   10'(rand_range(0, 1023))};
            end
            run_row(16'h3C00, b_w, '0, b_w, '1, "identity");
        end
    endtask

    task automatic check_integers();
        logic [15:0]      a_w;
        logic [ROW_W-1:0] b_w, c_w, e_w;
        for (int r = 0; r < 8; r++) begin
            build_int_row(a_w, b_w, c_w, e_w);
            run_row(a_w, b_w, c_w, e_w, '1, "integer");
        end
        // subnormal b with small c gives both subnormal and normal results
        b_w = {to_fp16(1023.0 * ULP_MIN), to_fp16(512.0 * ULP_MIN),
               to_fp16(-7.0 * ULP_MIN), to_fp16(5.0 * ULP_MIN)};
        c_w = {to_fp16(-1.0 * ULP_MIN), 16'h0000, 16'h0000, to_fp16(2.0 * ULP_MIN)};
        e_w = {to_fp16(3068.0 * ULP_MIN), to_fp16(1536.0 * ULP_MIN),
               to_fp16(-21.0 * ULP_MIN), to_fp16(17.0 * ULP_MIN)};
        run_row(to_fp16(3.0), b_w, c_w, e_w, '1, "subnormal b");
    endtask

    task automatic check_rounding();
        logic [ROW_W-1:0] b_w, c_w, e_w;
        b_w = {to_fp16(-32.0), to_fp16(32.0), to_fp16(32.0), to_fp16(32.0)};
        // ties at 2049, 2051, 2053 and -2049
        c_w = {to_fp16(-1.0), to_fp16(5.0), to_fp16(3.0), to_fp16(1.0)};
        e_w = {to_fp16(-2049.0), to_fp16(2053.0), to_fp16(2051.0), to_fp16(2049.0)};
        run_row(to_fp16(64.0), b_w, c_w, e_w, '1, "round tie");
        // below and above the halfway point
        b_w = {to_fp16(32.0), to_fp16(32.0), to_fp16(32.0), to_fp16(32.0)};
        c_w = {to_fp16(5.5), to_fp16(0.5), to_fp16(3.5), to_fp16(2.5)};
        e_w = {to_fp16(2053.5), to_fp16(2048.5), to_fp16(2051.5), to_fp16(2050.5)};
        run_row(to_fp16(64.0), b_w, c_w, e_w, '1, "round sticky");
    endtask

    task automatic check_dominant_cancel();
        logic [15:0]      a_w;
        logic [ROW_W-1:0] b_w, c_w, e_w;
        int               ai;
        int               bi;
        // product near 1.0 against c at exponent 14 or 15
        for (int r = 0; r < 3; r++) begin
            for (int l = 0; l < LANES; l++) begin
                b_w[l*16 +: 16] = {1'(rand_range(0, 1)), 5'd15, 10'(rand_range(0, 1023))};
                c_w[l*16 +: 16] = {1'(rand_range(0, 1)), 5'(rand_range(29, 30)),
                                   10'(rand_range(0, 1023))};
            end
            run_row(16'h3C00, b_w, c_w, c_w, '1, "c dominant");
        end
        for (int r = 0; r < 3; r++) begin
            ai  = rand_range(-15, 15);
            ai  = (ai == 0) ? 7 : ai;
            a_w = to_fp16(real'(ai));
            for (int l = 0; l < LANES; l++) begin
                bi = rand_range(-31, 31);
                bi = (bi == 0) ? -3 : bi;
                b_w[l*16 +: 16] = to_fp16(real'(bi));
                c_w[l*16 +: 16] = to_fp16(real'(-(ai * bi)));
            end
            // sign of the exact zero is left open
            run_row(a_w, b_w, c_w, '0, {LANES{16'h7FFF}}, "cancellation");
        end
    endtask

    task automatic check_pipeline();
        logic [15:0]      a_w [3];
        logic [ROW_W-1:0] b_w [3];
        logic [ROW_W-1:0] c_w [3];
        logic [ROW_W-1:0] e_w [3];
        for (int k = 0; k < 3; k++) begin
            build_int_row(a_w[k], b_w[k], c_w[k], e_w[k]);
        end
        // one new row per cycle with row i checked two falling edges later
        for (int i = 0; i < 5; i++) begin
            if (i >= 2) begin
                compare_row(e_w[i-2], '1, "pipeline");
            end
            if (i < 3) begin
                drive_row(a_w[i], b_w[i], c_w[i]);
            end
            next_fall(1);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the test sequence did not finish within %0d ns", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        clk    = 1'b0;
        rst    = 1'b1;
        // nonzero operands during reset so only the clear can leave the output at zero
        a      = 16'h3C00;
        row_b  = {LANES{16'h4000}};
        row_c  = '0;
        seed   = 61427;
        errors = 0;
        checks = 0;
        next_fall(10);
        rst = 1'b0;
        compare_row('0, '1, "reset");

        check_identity();
        check_integers();
        check_rounding();
        check_dominant_cancel();
        check_pipeline();

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
hw/fma_pkg.sv
hw/fma_ifs.sv
hw/fp16_unpack.sv
hw/booth_multiples.sv
hw/booth_lane_select.sv
hw/fma_align_add.sv
hw/fma_normalize_round.sv
hw/fma_row.sv
tests/tb_fma_row.sv

/* Makefile */
# Verilator build and run of the FMA row testbench

VERILATOR ?= verilator
TOP       ?= tb_fma_row
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

PASS_MSG  := Simulation completed successfully
SOURCES   := $(shell cat $(FILELIST))
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
